// ==== vlog.f ====
+incdir+.
dbg_pkg.sv
sys_pkg.sv
wb_sram.sv
wb_arbiter.sv
sum_hart.sv
dbg_module.sv
dbg_soc_top.sv
tb_dbg_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_dbg_soc -f vlog.f

./obj_dir/Vtb_dbg_soc | tee sim.log

if grep -q "Test FAILED" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi

echo "Simulation finished without failure"

// ==== tb_dbg_soc.sv ====
// Debug preload subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module tb_dbg_soc import dbg_pkg::*; ();

   localparam int CLK_HALF   = 4;
   localparam int WORDS      = 1 << `SRAM_AW;
   localparam int PRE_LEN    = 64;
   localparam int NUM_LISTS  = 4;
   localparam int LONG_BASE  = 144;
   localparam int LONG_LEN   = 100;
   localparam int SHORT_BASE = 248;
   localparam int SHORT_LEN  = 4;
   localparam int POLL_MAX   = 1000;

   // Rough count of DMI accesses, polls included
   localparam int PLANNED_DMI = 32 + 2 * PRE_LEN * 4
                              + NUM_LISTS * (8 + 17 * 6)
                              + (8 + (LONG_LEN + 1) * 6)
                              + 4 * 24
                              + (8 + (SHORT_LEN + 1) * 6);

   // Register bit positions
   localparam int SBCS_BUSYERR  = 22;
   localparam int SBCS_BUSY     = 21;
   localparam int SBCS_RDONADDR = 20;
   localparam int SBCS_AUTOINC  = 16;
   localparam int SBCS_RDONDATA = 15;
   localparam int DMS_ANYHALT   = 8;
   localparam int DMS_ALLHALT   = 9;
   localparam int DMC_HALT      = 31;
   localparam int DMC_RESUME    = 30;

   logic               clk_sys;
   logic               arst_n;
   logic               dmi_req;
   logic               dmi_we;
   dmi_addr_e          dmi_addr;
   logic [`DATA_W-1:0] dmi_wdata;
   logic [`DATA_W-1:0] dmi_rdata;
   logic               dmi_ack;
   logic               halted;

   logic [31:0]        lfsr_state;
   logic [`DATA_W-1:0] mem_model [0:WORDS-1];
   int                 word_errs;
   int                 flag_errs;
   int                 other_errs;

   dbg_soc_top uut (
      .clk_sys     (clk_sys),
      .arst_n_i    (arst_n),
      .dmi_req_i   (dmi_req),
      .dmi_we_i    (dmi_we),
      .dmi_addr_i  (dmi_addr),
      .dmi_wdata_i (dmi_wdata),
      .dmi_rdata_o (dmi_rdata),
      .dmi_ack_o   (dmi_ack),
      .halted_o    (halted)
   );

   initial begin
      clk_sys = 1'b0;
      forever #(CLK_HALF) clk_sys = ~clk_sys;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
         v = {v[30:0], next_bit()};
      return v;
   endfunction

   function automatic logic [`DATA_W-1:0] rand_nonzero();
      logic [`DATA_W-1:0] w;
      w = rand_bits(`DATA_W);
      if (w == '0)
         w = `DATA_W'(1);
      return w;
   endfunction

   // Hart rule, add words until a zero word
   function automatic logic [`DATA_W-1:0] model_sum(input int base);
      logic [`DATA_W-1:0] sum;
      int                 idx;
      sum = '0;
      idx = base;
      while (mem_model[idx] != '0) begin
         sum = sum + mem_model[idx];
         idx = (idx + 1) % WORDS;
      end
      return sum;
   endfunction

   // Sum of the first k list words for some k below len
   function automatic bit partial_sum_matches(input int base, input int len,
                                              input logic [`DATA_W-1:0] value);
      logic [`DATA_W-1:0] sum;
      int                 k;
      sum = '0;
      for (k = 0; k < len; k++) begin
         if (value === sum)
            return 1'b1;
         sum = sum + mem_model[(base + k) % WORDS];
      end
      return 1'b0;
   endfunction

   task automatic check_word(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
      if (got !== exp) begin
         word_errs++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errs++;
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   // One DMI request, held until ack
   task automatic dmi_access(input logic we, input dmi_addr_e addr,
                             input logic [`DATA_W-1:0] wdata,
                             output logic [`DATA_W-1:0] rdata);
      @(negedge clk_sys);
      // Ack of the previous request lasts a single cycle
      check_flag("dmi_ack_o", dmi_ack, 1'b0);
      dmi_req   = 1'b1;
      dmi_we    = we;
      dmi_addr  = addr;
      dmi_wdata = wdata;
      @(negedge clk_sys);
      // Ack follows the first sampled request cycle
      check_flag("dmi_ack_o", dmi_ack, 1'b1);
      while (!dmi_ack)
         @(negedge clk_sys);
      rdata   = dmi_rdata;
      dmi_req = 1'b0;
   endtask

   task automatic dmi_write(input dmi_addr_e addr, input logic [`DATA_W-1:0] wdata);
      logic [`DATA_W-1:0] unused;
      dmi_access(1'b1, addr, wdata, unused);
   endtask

   task automatic dmi_read(input dmi_addr_e addr, output logic [`DATA_W-1:0] rdata);
      dmi_access(1'b0, addr, '0, rdata);
   endtask

   task automatic wait_sba_idle();
      logic [`DATA_W-1:0] sbcs;
      int                 polls;
      polls = 0;
      dmi_read(DMI_SBCS, sbcs);
      while (sbcs[SBCS_BUSY] && (polls < POLL_MAX)) begin
         polls++;
         dmi_read(DMI_SBCS, sbcs);
      end
      if (sbcs[SBCS_BUSY]) begin
         other_errs++;
         $display("SBA access still busy after %0d polls at %0t", polls, $time);
      end
   endtask

   task automatic wait_halted();
      logic [`DATA_W-1:0] status;
      int                 polls;
      polls = 0;
      dmi_read(DMI_DMSTATUS, status);
      while (!status[DMS_ALLHALT] && (polls < POLL_MAX)) begin
         polls++;
         dmi_read(DMI_DMSTATUS, status);
      end
      if (!status[DMS_ALLHALT]) begin
         other_errs++;
         $display("Hart did not halt after %0d polls at %0t", polls, $time);
      end
   endtask

   // Write model words into the SRAM through SBA
   task automatic load_words(input int base, input int count);
      int i;
      dmi_write(DMI_SBCS, 1 << SBCS_AUTOINC);
      dmi_write(DMI_SBADDRESS0, 32'(base * 4));
      for (i = 0; i < count; i++) begin
         dmi_write(DMI_SBDATA0, mem_model[(base + i) % WORDS]);
         wait_sba_idle();
      end
   endtask

   // Read on address starts the first read, read on data the rest
   task automatic read_words(input int base, input int count);
      logic [`DATA_W-1:0] data;
      int                 i;
      dmi_write(DMI_SBCS, (1 << SBCS_RDONADDR) | (1 << SBCS_AUTOINC) |
                          (1 << SBCS_RDONDATA));
      dmi_write(DMI_SBADDRESS0, 32'(base * 4));
      for (i = 0; i < count; i++) begin
         wait_sba_idle();
         dmi_read(DMI_SBDATA0, data);
         check_word($sformatf("sbdata0[%0d]", (base + i) % WORDS), data,
                    mem_model[(base + i) % WORDS]);
      end
      wait_sba_idle();
   endtask

   task automatic make_list(input int base, input int len);
      int i;
      for (i = 0; i < len; i++)
         mem_model[(base + i) % WORDS] = rand_nonzero();
      mem_model[(base + len) % WORDS] = '0;
      load_words(base, len + 1);
   endtask

   task automatic start_hart(input int base);
      dmi_write(DMI_DATA0, 32'(base * 4));
      dmi_write(DMI_DMCONTROL, 1 << DMC_RESUME);
   endtask

   task automatic run_hart(input int base);
      logic [`DATA_W-1:0] result;
      start_hart(base);
      wait_halted();
      dmi_read(DMI_DATA1, result);
      check_word($sformatf("data1 list@%0d", base), result, model_sum(base));
   endtask

   task automatic check_reset_state();
      logic [`DATA_W-1:0] rd;
      dmi_read(DMI_DMSTATUS, rd);
      check_flag("dmstatus.allhalted", rd[DMS_ALLHALT], 1'b1);
      check_flag("dmstatus.anyhalted", rd[DMS_ANYHALT], 1'b1);
      dmi_read(DMI_SBCS, rd);
      check_flag("sbcs.sbbusy", rd[SBCS_BUSY], 1'b0);
      check_flag("sbcs.sbbusyerror", rd[SBCS_BUSYERR], 1'b0);
      check_flag("sbcs.sbautoincrement", rd[SBCS_AUTOINC], 1'b0);
      check_flag("sbcs.sbreadondata", rd[SBCS_RDONDATA], 1'b0);
      dmi_read(DMI_DATA1, rd);
      check_word("data1", rd, '0);
      check_flag("halted_o", halted, 1'b1);
   endtask

   task automatic preload_and_readback();
      int i;
      for (i = 0; i < PRE_LEN; i++)
         mem_model[i] = rand_bits(`DATA_W);
      load_words(0, PRE_LEN);
      read_words(0, PRE_LEN);
   endtask

   // Second write lands while the first is still on the bus
   task automatic provoke_busy_error();
      logic [`DATA_W-1:0] v1;
      logic [`DATA_W-1:0] rd;
      v1 = rand_nonzero();
      dmi_write(DMI_SBCS, '0);
      dmi_write(DMI_SBADDRESS0, 32'(40 * 4));
      dmi_write(DMI_SBDATA0, v1);
      dmi_write(DMI_SBDATA0, ~v1);
      mem_model[40] = v1;
      wait_sba_idle();
      dmi_read(DMI_SBCS, rd);
      check_flag("sbcs.sbbusyerror", rd[SBCS_BUSYERR], 1'b1);
      dmi_write(DMI_SBCS, 1 << SBCS_BUSYERR);
      dmi_read(DMI_SBCS, rd);
      check_flag("sbcs.sbbusyerror", rd[SBCS_BUSYERR], 1'b0);
      read_words(40, 1);
   endtask

   task automatic run_sum_lists();
      int r;
      int base;
      int len;
      for (r = 0; r < NUM_LISTS; r++) begin
         base = 64 + int'(rand_bits(6));
         len  = 1 + int'(rand_bits(4));
         make_list(base, len);
         run_hart(base);
      end
   endtask

   task automatic halt_under_contention();
      logic [`DATA_W-1:0] result;
      int                 r;
      make_list(LONG_BASE, LONG_LEN);
      start_hart(LONG_BASE);
      // SBA readbacks compete with the hart fetches
      for (r = 0; r < 4; r++)
         read_words(int'(rand_bits(5)), 4);
      dmi_write(DMI_DMCONTROL, 1 << DMC_HALT);
      wait_halted();
      check_flag("halted_o", halted, 1'b1);
      // Halted part way, so only a prefix of the list was added
      dmi_read(DMI_DATA1, result);
      if (!partial_sum_matches(LONG_BASE, LONG_LEN, result)) begin
         other_errs++;
         $display("Halted hart sum %h is no prefix sum of the long list at %0t",
                  result, $time);
      end
      make_list(SHORT_BASE, SHORT_LEN);
      run_hart(SHORT_BASE);
   endtask

   initial begin
      #(PLANNED_DMI * 40 * 2 * CLK_HALF);
      $display("Watchdog expired before the tests finished");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      lfsr_state = 32'd98662;
      word_errs  = 0;
      flag_errs  = 0;
      other_errs = 0;
      arst_n     = 1'b0;
      dmi_req    = 1'b0;
      dmi_we     = 1'b0;
      dmi_addr   = DMI_DATA0;
      dmi_wdata  = '0;
      repeat (4) @(negedge clk_sys);
      arst_n = 1'b1;

      check_reset_state();
      preload_and_readback();
      provoke_busy_error();
      run_sum_lists();
      halt_under_contention();

      $display("Errors: %0d word, %0d flag, %0d other", word_errs, flag_errs, other_errs);
      if ((word_errs + flag_errs + other_errs) == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dbg_soc_top.sv ====
// Debug preload subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module dbg_soc_top import dbg_pkg::*; (
   input  wire                clk_sys,
   input  wire                arst_n_i,
   input  wire                dmi_req_i,
   input  wire                dmi_we_i,
   input  wire dmi_addr_e     dmi_addr_i,
   input  wire [`DATA_W-1:0]  dmi_wdata_i,
   output logic [`DATA_W-1:0] dmi_rdata_o,
   output logic               dmi_ack_o,
   output logic               halted_o
);

   logic               dbg_cyc;
   logic               dbg_stb;
   logic               dbg_we;
   logic [`ADDR_W-1:0] dbg_adr;
   logic [`DATA_W-1:0] dbg_dat_w;
   logic [`DATA_W-1:0] dbg_dat_r;
   logic               dbg_ack;

   logic               hart_cyc;
   logic               hart_stb;
   logic               hart_we;
   logic [`ADDR_W-1:0] hart_adr;
   logic [`DATA_W-1:0] hart_dat_w;
   logic [`DATA_W-1:0] hart_dat_r;
   logic               hart_ack;

   logic               mem_cyc;
   logic               mem_stb;
   logic               mem_we;
   logic [`ADDR_W-1:0] mem_adr;
   logic [`DATA_W-1:0] mem_dat_w;
   logic [`DATA_W-1:0] mem_dat_r;
   logic               mem_ack;

   logic               halt_req;
   logic               resume_req;
   logic [`ADDR_W-1:0] resume_pc;
   logic [`DATA_W-1:0] hart_result;

   dbg_module u_dbg (
      .clk_sys       (clk_sys),
      .arst_n_i      (arst_n_i),
      .dmi_req_i     (dmi_req_i),
      .dmi_we_i      (dmi_we_i),
      .dmi_addr_i    (dmi_addr_i),
      .dmi_wdata_i   (dmi_wdata_i),
      .dmi_rdata_o   (dmi_rdata_o),
      .dmi_ack_o     (dmi_ack_o),
      .wb_cyc_o      (dbg_cyc),
      .wb_stb_o      (dbg_stb),
      .wb_we_o       (dbg_we),
      .wb_adr_o      (dbg_adr),
      .wb_dat_o      (dbg_dat_w),
      .wb_dat_i      (dbg_dat_r),
      .wb_ack_i      (dbg_ack),
      .halt_req_o    (halt_req),
      .resume_req_o  (resume_req),
      .resume_pc_o   (resume_pc),
      .hart_halted_i (halted_o),
      .hart_result_i (hart_result)
   );

   sum_hart u_hart (
      .clk_sys      (clk_sys),
      .arst_n_i     (arst_n_i),
      .halt_req_i   (halt_req),
      .resume_req_i (resume_req),
      .resume_pc_i  (resume_pc),
      .halted_o     (halted_o),
      .result_o     (hart_result),
      .wb_cyc_o     (hart_cyc),
      .wb_stb_o     (hart_stb),
      .wb_we_o      (hart_we),
      .wb_adr_o     (hart_adr),
      .wb_dat_o     (hart_dat_w),
      .wb_dat_i     (hart_dat_r),
      .wb_ack_i     (hart_ack)
   );

   // Debug module on m0, hart on m1
   wb_arbiter u_arb (
      .clk_sys  (clk_sys),
      .arst_n_i (arst_n_i),
      .m0_cyc_i (dbg_cyc),
      .m0_stb_i (dbg_stb),
      .m0_we_i  (dbg_we),
      .m0_adr_i (dbg_adr),
      .m0_dat_i (dbg_dat_w),
      .m0_dat_o (dbg_dat_r),
      .m0_ack_o (dbg_ack),
      .m1_cyc_i (hart_cyc),
      .m1_stb_i (hart_stb),
      .m1_we_i  (hart_we),
      .m1_adr_i (hart_adr),
      .m1_dat_i (hart_dat_w),
      .m1_dat_o (hart_dat_r),
      .m1_ack_o (hart_ack),
      .s_cyc_o  (mem_cyc),
      .s_stb_o  (mem_stb),
      .s_we_o   (mem_we),
      .s_adr_o  (mem_adr),
      .s_dat_o  (mem_dat_w),
      .s_dat_i  (mem_dat_r),
      .s_ack_i  (mem_ack)
   );

   wb_sram u_sram (
      .clk_sys  (clk_sys),
      .arst_n_i (arst_n_i),
      .wb_cyc_i (mem_cyc),
      .wb_stb_i (mem_stb),
      .wb_we_i  (mem_we),
      .wb_adr_i (mem_adr),
      .wb_dat_i (mem_dat_w),
      .wb_dat_o (mem_dat_r),
      .wb_ack_o (mem_ack)
   );

endmodule

`default_nettype wire

// ==== dbg_module.sv ====
// Debug module with SBA and run control
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module dbg_module import dbg_pkg::*; (
   input  wire                clk_sys,
   input  wire                arst_n_i,
   // DMI register port
   input  wire                dmi_req_i,
   input  wire                dmi_we_i,
   input  wire dmi_addr_e     dmi_addr_i,
   input  wire [`DATA_W-1:0]  dmi_wdata_i,
   output logic [`DATA_W-1:0] dmi_rdata_o,
   output logic               dmi_ack_o,
   // Wishbone master towards the SRAM
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output logic [`ADDR_W-1:0] wb_adr_o,
   output logic [`DATA_W-1:0] wb_dat_o,
   input  wire [`DATA_W-1:0]  wb_dat_i,
   input  wire                wb_ack_i,
   // Hart run control
   output logic               halt_req_o,
   output logic               resume_req_o,
   output logic [`ADDR_W-1:0] resume_pc_o,
   input  wire                hart_halted_i,
   input  wire [`DATA_W-1:0]  hart_result_i
);

   logic               req_q;
   logic               ack_q;
   logic               dmi_acc;
   logic               dmi_wr;
   logic               dmi_rd;
   logic [`DATA_W-1:0] rdata_q;
   logic [`DATA_W-1:0] data0_q;
   logic               halt_q;
   logic               resume_q;
   logic               busyerr_q;
   logic               readonaddr_q;
   logic               autoinc_q;
   logic               readondata_q;
   logic [`ADDR_W-1:0] sbaddr_q;
   logic [`DATA_W-1:0] sbdata_q;
   sba_state_e         sba_state_q;
   logic               sbbusy;
   logic               sba_start_wr;
   logic               sba_start_rd;
   logic               sba_touch;
   logic [`DATA_W-1:0] sbcs_val;
   logic [`DATA_W-1:0] dmstatus_val;

   // One access per request, on its first sampled cycle
   assign dmi_acc = dmi_req_i & ~req_q;
   assign dmi_wr  = dmi_acc & dmi_we_i;
   assign dmi_rd  = dmi_acc & ~dmi_we_i;
   assign sbbusy  = (sba_state_q != SBA_IDLE);

   assign sba_start_wr = dmi_wr && (dmi_addr_i == DMI_SBDATA0);
   assign sba_start_rd = (dmi_wr && (dmi_addr_i == DMI_SBADDRESS0) && readonaddr_q) ||
                         (dmi_rd && (dmi_addr_i == DMI_SBDATA0) && readondata_q);
   // Anything that would disturb a running bus access
   assign sba_touch = sba_start_wr || sba_start_rd ||
                      (dmi_wr && (dmi_addr_i == DMI_SBADDRESS0));

   always_comb begin
      sbcs_val        = '0;
      sbcs_val[31:29] = 3'd1;
      sbcs_val[22]    = busyerr_q;
      sbcs_val[21]    = sbbusy;
      sbcs_val[20]    = readonaddr_q;
      sbcs_val[19:17] = 3'd2;        // 32-bit access
      sbcs_val[16]    = autoinc_q;
      sbcs_val[15]    = readondata_q;
      sbcs_val[11:5]  = 7'd32;
      sbcs_val[2]     = 1'b1;
   end

   always_comb begin
      dmstatus_val        = '0;
      dmstatus_val[11]    = ~hart_halted_i;
      dmstatus_val[10]    = ~hart_halted_i;
      dmstatus_val[9]     = hart_halted_i;
      dmstatus_val[8]     = hart_halted_i;
      dmstatus_val[3:0]   = 4'd2;
   end

   // DMI handshake and run control registers
   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         req_q        <= 1'b0;
         ack_q        <= 1'b0;
         halt_q       <= 1'b0;
         resume_q     <= 1'b0;
         data0_q      <= '0;
         busyerr_q    <= 1'b0;
         readonaddr_q <= 1'b0;
         autoinc_q    <= 1'b0;
         readondata_q <= 1'b0;
      end else begin
         req_q    <= dmi_req_i;
         ack_q    <= dmi_acc;
         halt_q   <= dmi_wr && (dmi_addr_i == DMI_DMCONTROL) && dmi_wdata_i[31];
         resume_q <= dmi_wr && (dmi_addr_i == DMI_DMCONTROL) && dmi_wdata_i[30];
         if (dmi_wr && (dmi_addr_i == DMI_DATA0))
            data0_q <= dmi_wdata_i;
         if (dmi_wr && (dmi_addr_i == DMI_SBCS)) begin
            readonaddr_q <= dmi_wdata_i[20];
            autoinc_q    <= dmi_wdata_i[16];
            readondata_q <= dmi_wdata_i[15];
            if (dmi_wdata_i[22])
               busyerr_q <= 1'b0;
         end
         // Sticky until cleared by software
         if (sbbusy && sba_touch)
            busyerr_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (dmi_rd) begin
         case (dmi_addr_i)
            DMI_DATA0:      rdata_q <= data0_q;
            DMI_DATA1:      rdata_q <= hart_result_i;
            DMI_DMSTATUS:   rdata_q <= dmstatus_val;
            DMI_SBCS:       rdata_q <= sbcs_val;
            DMI_SBADDRESS0: rdata_q <= sbaddr_q;
            DMI_SBDATA0:    rdata_q <= sbdata_q;
            default:        rdata_q <= '0;
         endcase
      end
   end

   // SBA engine, new accesses only start from idle
   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sba_state_q <= SBA_IDLE;
         sbaddr_q    <= '0;
         sbdata_q    <= '0;
      end else begin
         case (sba_state_q)
            SBA_IDLE: begin
               if (dmi_wr && (dmi_addr_i == DMI_SBADDRESS0))
                  sbaddr_q <= dmi_wdata_i[`ADDR_W-1:0];
               if (sba_start_wr) begin
                  sbdata_q    <= dmi_wdata_i;
                  sba_state_q <= SBA_WRITE;
               end else if (sba_start_rd) begin
                  sba_state_q <= SBA_READ;
               end
            end
            default: begin
               if (wb_ack_i) begin
                  if (sba_state_q == SBA_READ)
                     sbdata_q <= wb_dat_i;
                  if (autoinc_q)
                     sbaddr_q <= sbaddr_q + `ADDR_W'(4);
                  sba_state_q <= SBA_IDLE;
               end
            end
         endcase
      end
   end

   assign dmi_ack_o   = ack_q;
   assign dmi_rdata_o = rdata_q;

   assign wb_cyc_o = sbbusy;
   assign wb_stb_o = sbbusy;
   assign wb_we_o  = (sba_state_q == SBA_WRITE);
   assign wb_adr_o = sbaddr_q;
   assign wb_dat_o = sbdata_q;

   assign halt_req_o   = halt_q;
   assign resume_req_o = resume_q;
   assign resume_pc_o  = data0_q[`ADDR_W-1:0];

endmodule

`default_nettype wire

// ==== sum_hart.sv ====
// Summing hart under debug control
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module sum_hart import sys_pkg::*; (
   input  wire                clk_sys,
   input  wire                arst_n_i,
   // Run control from the debug module
   input  wire                halt_req_i,
   input  wire                resume_req_i,
   input  wire [`ADDR_W-1:0]  resume_pc_i,
   output logic               halted_o,
   output logic [`DATA_W-1:0] result_o,
   // Wishbone master, read only
   output logic               wb_cyc_o,
   output logic               wb_stb_o,
   output logic               wb_we_o,
   output logic [`ADDR_W-1:0] wb_adr_o,
   output logic [`DATA_W-1:0] wb_dat_o,
   input  wire [`DATA_W-1:0]  wb_dat_i,
   input  wire                wb_ack_i
);

   hart_state_e        state_q;
   logic [`ADDR_W-1:0] addr_q;
   logic [`DATA_W-1:0] sum_q;
   logic [`DATA_W-1:0] word_q;
   logic               halt_pend_q;

   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= HART_HALTED;
         addr_q      <= '0;
         sum_q       <= '0;
         halt_pend_q <= 1'b0;
      end else begin
         case (state_q)
            HART_HALTED: begin
               // Halt while halted has nothing to do
               if (resume_req_i) begin
                  addr_q      <= resume_pc_i;
                  sum_q       <= '0;
                  halt_pend_q <= 1'b0;
                  state_q     <= HART_FETCH;
               end
            end
            HART_FETCH: begin
               if (halt_req_i)
                  halt_pend_q <= 1'b1;
               if (wb_ack_i)
                  state_q <= HART_CHECK;
            end
            default: begin
               // Word in hand still counts, then stop on zero or halt
               if (word_q != '0)
                  sum_q <= sum_q + word_q;
               if ((word_q == '0) || halt_pend_q || halt_req_i) begin
                  halt_pend_q <= 1'b0;
                  state_q     <= HART_HALTED;
               end else begin
                  addr_q  <= addr_q + `ADDR_W'(4);
                  state_q <= HART_FETCH;
               end
            end
         endcase
      end
   end

   // Fetched word
   always_ff @(posedge clk_sys) begin
      if ((state_q == HART_FETCH) && wb_ack_i)
         word_q <= wb_dat_i;
   end

   assign halted_o = (state_q == HART_HALTED);
   assign result_o = sum_q;

   assign wb_cyc_o = (state_q == HART_FETCH);
   assign wb_stb_o = (state_q == HART_FETCH);
   assign wb_we_o  = 1'b0;
   assign wb_adr_o = addr_q;
   assign wb_dat_o = '0;

endmodule

`default_nettype wire

// ==== wb_arbiter.sv ====
// Two master Wishbone round robin arbiter
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module wb_arbiter import sys_pkg::*; (
   input  wire                clk_sys,
   input  wire                arst_n_i,
   // Master 0
   input  wire                m0_cyc_i,
   input  wire                m0_stb_i,
   input  wire                m0_we_i,
   input  wire [`ADDR_W-1:0]  m0_adr_i,
   input  wire [`DATA_W-1:0]  m0_dat_i,
   output logic [`DATA_W-1:0] m0_dat_o,
   output logic               m0_ack_o,
   // Master 1
   input  wire                m1_cyc_i,
   input  wire                m1_stb_i,
   input  wire                m1_we_i,
   input  wire [`ADDR_W-1:0]  m1_adr_i,
   input  wire [`DATA_W-1:0]  m1_dat_i,
   output logic [`DATA_W-1:0] m1_dat_o,
   output logic               m1_ack_o,
   // Slave
   output logic               s_cyc_o,
   output logic               s_stb_o,
   output logic               s_we_o,
   output logic [`ADDR_W-1:0] s_adr_o,
   output logic [`DATA_W-1:0] s_dat_o,
   input  wire [`DATA_W-1:0]  s_dat_i,
   input  wire                s_ack_i
);

   grant_e owner_q;
   grant_e pick;
   logic   last_hart_q;

   // Favour the master that was not granted last
   always_comb begin
      pick = GNT_NONE;
      if (m0_cyc_i && (!m1_cyc_i || last_hart_q))
         pick = GNT_DBG;
      else if (m1_cyc_i)
         pick = GNT_HART;
   end

   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i) begin
         owner_q     <= GNT_NONE;
         last_hart_q <= 1'b0;
      end else begin
         case (owner_q)
            GNT_NONE: begin
               owner_q <= pick;
               if (pick != GNT_NONE)
                  last_hart_q <= (pick == GNT_HART);
            end
            GNT_DBG:  if (!m0_cyc_i) owner_q <= GNT_NONE;
            default:  if (!m1_cyc_i) owner_q <= GNT_NONE;
         endcase
      end
   end

   always_comb begin
      s_cyc_o = 1'b0;
      s_stb_o = 1'b0;
      s_we_o  = m0_we_i;
      s_adr_o = m0_adr_i;
      s_dat_o = m0_dat_i;
      case (owner_q)
         GNT_DBG: begin
            s_cyc_o = m0_cyc_i;
            s_stb_o = m0_stb_i;
         end
         GNT_HART: begin
            s_cyc_o = m1_cyc_i;
            s_stb_o = m1_stb_i;
            s_we_o  = m1_we_i;
            s_adr_o = m1_adr_i;
            s_dat_o = m1_dat_i;
         end
         default: ;
      endcase
   end

   // Read data is shared, ack goes to the owner only
   assign m0_dat_o = s_dat_i;
   assign m1_dat_o = s_dat_i;
   assign m0_ack_o = s_ack_i && (owner_q == GNT_DBG);
   assign m1_ack_o = s_ack_i && (owner_q == GNT_HART);

endmodule

`default_nettype wire

// ==== wb_sram.sv ====
// Word SRAM with Wishbone slave port
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module wb_sram (
   input  wire                clk_sys,
   input  wire                arst_n_i,
   input  wire                wb_cyc_i,
   input  wire                wb_stb_i,
   input  wire                wb_we_i,
   input  wire [`ADDR_W-1:0]  wb_adr_i,
   input  wire [`DATA_W-1:0]  wb_dat_i,
   output logic [`DATA_W-1:0] wb_dat_o,
   output logic               wb_ack_o
);

   logic [`DATA_W-1:0] mem [0:(1 << `SRAM_AW)-1];
   logic [`SRAM_AW-1:0] idx;
   logic                access;

   // Word index, upper address bits ignored
   assign idx    = wb_adr_i[`SRAM_AW+1:2];
   assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

   always_ff @(posedge clk_sys or negedge arst_n_i) begin
      if (!arst_n_i)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= access;
   end

   always_ff @(posedge clk_sys) begin
      if (access) begin
         if (wb_we_i)
            mem[idx] <= wb_dat_i;
         wb_dat_o <= mem[idx];
      end
   end

endmodule

`default_nettype wire

// ==== sys_pkg.sv ====
// System side types
`default_nettype none

package sys_pkg;

   // Summing hart run state
   typedef enum logic [1:0] {
      HART_HALTED,
      HART_FETCH,
      HART_CHECK
   } hart_state_e;

   // Current owner of the shared SRAM bus
   typedef enum logic [1:0] {
      GNT_NONE,
      GNT_DBG,
      GNT_HART
   } grant_e;

endpackage

`default_nettype wire

// ==== dbg_pkg.sv ====
// Debug side types
`default_nettype none

package dbg_pkg;

   // DMI register map, only the implemented subset
   typedef enum logic [6:0] {
      DMI_DATA0      = 7'h04,
      DMI_DATA1      = 7'h05,
      DMI_DMCONTROL  = 7'h10,
      DMI_DMSTATUS   = 7'h11,
      DMI_SBCS       = 7'h38,
      DMI_SBADDRESS0 = 7'h39,
      DMI_SBDATA0    = 7'h3C
   } dmi_addr_e;

   // System bus access engine
   typedef enum logic [1:0] {
      SBA_IDLE,
      SBA_WRITE,
      SBA_READ
   } sba_state_e;

endpackage

`default_nettype wire

// ==== soc_defs.svh ====
// Shared widths and sizes

`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus and register data width, one word
`define DATA_W 32

// Byte address width on the system bus
`define ADDR_W 32

// SRAM word index width, 256 words
`define SRAM_AW 8

`endif
